// File: sim.f
+incdir+include
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_sequencer.sv
source/eeprom_wr.sv
sim/clock_gen.sv
sim/eeprom_model.sv
sim/eeprom_wr_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f sim.f --top-module eeprom_wr_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Veeprom_wr_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -qx "Verification passed" || exit 1
exit 0

// File: sim/eeprom_wr_tb.sv
`include "eeprom_consts.svh"

module eeprom_wr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_BOTH = 2;       // wr and rd in the same cycle
    localparam int OP_WR_STRAY = 3;   // write plus a strobe while busy
    localparam int MAX_ROWS = 64;
    localparam int ACK_TIMEOUT = 250 * `EE_HALF_SCL;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  ack;
    logic                  busy;
    logic                  nack;
    logic                  scl;
    logic                  sda_pull;
    logic                  model_pull;
    logic                  model_no_ack;
    logic                  sda_line;

    int                    tbl_op [MAX_ROWS];
    logic [`EE_ADDR_W-1:0] tbl_addr [MAX_ROWS];
    logic [`EE_DATA_W-1:0] tbl_wdata [MAX_ROWS];
    logic                  tbl_no_ack [MAX_ROWS];
    logic [`EE_DATA_W-1:0] tbl_exp_rdata [MAX_ROWS];
    logic                  tbl_exp_nack [MAX_ROWS];
    logic [`EE_DATA_W-1:0] shadow [1 << `EE_ADDR_W];
    int                    n_rows;
    int                    mismatches;
    int                    timeouts;
    int                    ack_count;
    logic [31:0]           rng;

    assign sda_line = !(sda_pull || model_pull);   // open-drain wired-AND

    clock_gen u_clk (.CLK(CLK), .RESET(RESET));

    eeprom_wr uut
    (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .ack(ack), .busy(busy), .nack(nack),
        .scl(scl), .sda_pull(sda_pull), .sda_in(sda_line)
    );

    eeprom_model u_mem
    (
        .CLK(CLK), .scl(scl), .sda(sda_line), .no_ack(model_no_ack), .sda_pull(model_pull)
    );

    always @(negedge CLK)
        if (ack === 1'b1)
            ack_count++;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // expected values come from the shadow copy as the table is built
    task automatic add_row(input int op, input logic [10:0] a, input logic [7:0] d,
                           input logic na);
        tbl_op[n_rows] = op;
        tbl_addr[n_rows] = a;
        tbl_wdata[n_rows] = d;
        tbl_no_ack[n_rows] = na;
        tbl_exp_rdata[n_rows] = shadow[a];
        tbl_exp_nack[n_rows] = na;
        if (op != OP_RD && !na)
            shadow[a] = d;
        n_rows++;
    endtask

    task automatic apply_row(input int i);
        int   cycles;
        logic seen;
        @(negedge CLK);
        model_no_ack = tbl_no_ack[i];
        addr = tbl_addr[i];
        wdata = tbl_wdata[i];
        wr = (tbl_op[i] != OP_RD);
        rd = (tbl_op[i] == OP_RD) || (tbl_op[i] == OP_BOTH);
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check(busy, 1, $sformatf("busy after request, row %0d", i));
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
            if (tbl_op[i] == OP_WR_STRAY && cycles == 40)
            begin
                addr = tbl_addr[i] ^ 11'h400;
                wdata = ~tbl_wdata[i];
                wr = 1'b1;
            end
            else if (cycles == 41)
                wr = 1'b0;
            seen = ack;
        end
        if (!seen)
        begin
            $display("Timeout: no ack within %0d cycles on row %0d", ACK_TIMEOUT, i);
            timeouts++;
        end
        else
        begin
            check(nack, tbl_exp_nack[i], $sformatf("nack, row %0d", i));
            check(busy, 0, $sformatf("busy with ack, row %0d", i));
            if (tbl_op[i] == OP_RD && !tbl_no_ack[i])
                check(rdata, tbl_exp_rdata[i], $sformatf("rdata, row %0d", i));
        end
    endtask

    initial
    begin
        int rows_done;
        int waited;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        model_no_ack = 1'b0;
        mismatches = 0;
        timeouts = 0;
        ack_count = 0;
        n_rows = 0;
        rows_done = 0;
        rng = 32'd45122;
        for (int a = 0; a < (1 << `EE_ADDR_W); a++)
            shadow[a] = 8'(a) ^ 8'h5A ^ {3'(a >> 8), 5'b00000};

        add_row(OP_RD, 11'h005, 8'h00, 1'b0);   // one read per block group
        add_row(OP_RD, 11'h1A3, 8'h00, 1'b0);
        add_row(OP_RD, 11'h2FF, 8'h00, 1'b0);
        add_row(OP_RD, 11'h7C0, 8'h00, 1'b0);
        add_row(OP_WR, 11'h1A3, 8'hC4, 1'b0);
        add_row(OP_RD, 11'h1A3, 8'h00, 1'b0);
        add_row(OP_WR, 11'h612, 8'h3E, 1'b0);
        add_row(OP_RD, 11'h612, 8'h00, 1'b0);
        add_row(OP_WR, 11'h0F0, 8'h11, 1'b1);   // refused write
        add_row(OP_RD, 11'h0F0, 8'h00, 1'b0);
        add_row(OP_RD, 11'h345, 8'h00, 1'b1);
        add_row(OP_RD, 11'h345, 8'h00, 1'b0);
        add_row(OP_BOTH, 11'h256, 8'h9D, 1'b0);
        add_row(OP_RD, 11'h256, 8'h00, 1'b0);
        add_row(OP_WR_STRAY, 11'h333, 8'h71, 1'b0);
        add_row(OP_RD, 11'h333, 8'h00, 1'b0);
        add_row(OP_RD, 11'h733, 8'h00, 1'b0);   // stray target untouched
        for (int k = 0; k < 24; k++)
        begin
            rng = xorshift32(rng);
            add_row(rng[0] ? OP_RD : OP_WR, rng[18:8], rng[31:24], rng[7:4] == 4'h0);
        end

        @(negedge CLK);
        waited = 0;
        while (RESET === 1'b1 && waited < 100)
        begin
            @(negedge CLK);
            waited++;
        end
        if (RESET !== 1'b0)
        begin
            $display("Reset was never released");
            timeouts++;
        end
        else
        begin
            @(negedge CLK);
            check(scl, 1, "scl after reset");
            check(sda_pull, 0, "sda_pull after reset");
            check({ack, busy, nack}, 0, "ack, busy, nack after reset");
            for (int i = 0; i < n_rows && timeouts == 0; i++)
            begin
                apply_row(i);
                rows_done++;
            end
            @(negedge CLK);
            check(busy, 0, "idle after last row");
            check(ack_count, rows_done, "number of ack pulses");
        end

        $display("Done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: sim/eeprom_model.sv
`include "eeprom_consts.svh"

module eeprom_model
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    input  logic no_ack,
    output logic sda_pull
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int M_IDLE = 0;
    localparam int M_RX = 1;
    localparam int M_ACK = 2;   // holding the ack bit for the master
    localparam int M_TX = 3;

    logic [`EE_DATA_W-1:0] mem [1 << `EE_ADDR_W];
    logic       scl_q;
    logic       sda_q;
    int         mode;
    int         bits;
    int         byte_idx;
    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic [2:0] block;
    logic [7:0] word;
    logic       rw;

    initial
    begin
        logic [`EE_ADDR_W-1:0] a;
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
        begin
            a = `EE_ADDR_W'(i);
            mem[i] = a[7:0] ^ 8'h5A ^ {a[10:8], 5'b00000};
        end
        scl_q = 1'b1;
        sda_q = 1'b1;
        sda_pull = 1'b0;
        mode = M_IDLE;
        bits = 0;
        byte_idx = 0;
        word = 8'h00;
        block = 3'b000;
        rw = 1'b0;
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda)
        begin
            mode <= M_RX;   // start or repeated start
            bits <= 0;
            byte_idx <= 0;
            sda_pull <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            mode <= M_IDLE;
            sda_pull <= 1'b0;
        end
        else if (scl && !scl_q && mode == M_RX)
        begin
            shift <= {shift[6:0], sda};
            bits <= bits + 1;
        end
        else if (!scl && scl_q)
        begin
            case (mode)
                M_RX:
                    if (bits == 8)
                    begin
                        if (no_ack || (byte_idx == 0 && shift[7:4] != `EE_DEV_CODE))
                            mode <= M_IDLE;   // stay off the bus
                        else
                        begin
                            mode <= M_ACK;
                            sda_pull <= 1'b1;
                            byte_idx <= byte_idx + 1;
                            if (byte_idx == 0)
                            begin
                                block <= shift[3:1];
                                rw <= shift[0];
                                tx_byte <= mem[{shift[3:1], word}];
                            end
                            else if (byte_idx == 1)
                                word <= shift;
                            else if (!rw)
                                mem[{block, word}] <= shift;
                        end
                    end
                M_ACK:
                begin
                    bits <= rw ? 1 : 0;
                    mode <= rw ? M_TX : M_RX;
                    sda_pull <= rw ? ~tx_byte[7] : 1'b0;
                    tx_byte <= {tx_byte[6:0], 1'b0};
                end
                M_TX:
                begin
                    if (bits < 8)
                    begin
                        sda_pull <= ~tx_byte[7];
                        tx_byte <= {tx_byte[6:0], 1'b0};
                    end
                    else
                        sda_pull <= 1'b0;   // master ack slot
                    bits <= bits + 1;
                    if (bits > 8)
                        mode <= M_IDLE;
                end
                default:
                    sda_pull <= 1'b0;
            endcase
        end
    end

endmodule

// File: sim/clock_gen.sv
module clock_gen
(
    output logic CLK,
    output logic RESET
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        CLK = 1'b0;
        RESET = 1'b1;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
    end

    always #4 CLK = ~CLK;   // 8 ns period

endmodule

// File: source/eeprom_wr.sv
`include "eeprom_consts.svh"

module eeprom_wr
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [`EE_ADDR_W-1:0]   addr,
    input  logic [`EE_DATA_W-1:0]   wdata,
    output logic [`EE_DATA_W-1:0]   rdata,
    output logic                    ack,
    output logic                    busy,
    output logic                    nack,
    output logic                    scl,
    output logic                    sda_pull,
    input  logic                    sda_in
);

    logic                   op_go;
    eeprom_pkg::bus_op_t    op;
    logic [`EE_DATA_W-1:0]  op_byte;
    logic                   op_last;
    logic                   op_done;
    logic [`EE_DATA_W-1:0]  rx_byte;
    logic                   rx_nack;

    eeprom_sequencer u_seq
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .ack     (ack),
        .busy    (busy),
        .nack    (nack),
        .op_go   (op_go),
        .op      (op),
        .op_byte (op_byte),
        .op_last (op_last),
        .op_done (op_done),
        .rx_byte (rx_byte),
        .rx_nack (rx_nack)
    );

    // open-drain side, wired-AND is resolved outside
    i2c_bit_engine u_bit
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_go    (op_go),
        .op       (op),
        .op_byte  (op_byte),
        .op_last  (op_last),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .rx_nack  (rx_nack),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

endmodule

// File: source/eeprom_sequencer.sv
`include "eeprom_consts.svh"

module eeprom_sequencer
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [`EE_ADDR_W-1:0]   addr,
    input  logic [`EE_DATA_W-1:0]   wdata,
    output logic [`EE_DATA_W-1:0]   rdata,
    output logic                    ack,
    output logic                    busy,
    output logic                    nack,
    output logic                    op_go,
    output eeprom_pkg::bus_op_t     op,
    output logic [`EE_DATA_W-1:0]   op_byte,
    output logic                    op_last,
    input  logic                    op_done,
    input  logic [`EE_DATA_W-1:0]   rx_byte,
    input  logic                    rx_nack
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t next_state;

    logic                   is_rd;
    logic                   pending;   // one symbol in flight
    logic                   err;
    logic [`EE_ADDR_W-1:0]  addr_r;
    logic [`EE_DATA_W-1:0]  wdata_r;
    logic                   accept;
    logic                   issue;

    eeprom_pkg::bus_op_t    sel_op;
    logic [`EE_DATA_W-1:0]  sel_byte;
    logic                   sel_last;
    logic [`EE_DATA_W-1:0]  ctrl_byte;

    assign busy = (state != eeprom_pkg::idle);
    assign accept = (state == eeprom_pkg::idle) && (wr || rd);
    assign issue = busy && !pending;

    // block select rides in the control byte, R/W bit patched per state
    assign ctrl_byte = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b0};

    always_comb
    begin
        sel_op = eeprom_pkg::op_start;
        sel_byte = ctrl_byte;
        sel_last = 1'b0;
        next_state = eeprom_pkg::idle;
        case (state)
            eeprom_pkg::start:
                next_state = eeprom_pkg::ctrl_wr;
            eeprom_pkg::ctrl_wr:
            begin
                sel_op = eeprom_pkg::op_write;
                next_state = eeprom_pkg::word_addr;
            end
            eeprom_pkg::word_addr:
            begin
                sel_op = eeprom_pkg::op_write;
                sel_byte = addr_r[7:0];
                next_state = is_rd ? eeprom_pkg::restart : eeprom_pkg::data_wr;
            end
            eeprom_pkg::data_wr:
            begin
                sel_op = eeprom_pkg::op_write;
                sel_byte = wdata_r;
                next_state = eeprom_pkg::stop;
            end
            eeprom_pkg::restart:
                next_state = eeprom_pkg::ctrl_rd;
            eeprom_pkg::ctrl_rd:
            begin
                sel_op = eeprom_pkg::op_write;
                sel_byte = ctrl_byte | `EE_DATA_W'(1);
                next_state = eeprom_pkg::data_rd;
            end
            eeprom_pkg::data_rd:
            begin
                sel_op = eeprom_pkg::op_read;
                sel_last = 1'b1;    // single byte, master nacks it
                next_state = eeprom_pkg::stop;
            end
            eeprom_pkg::stop:
            begin
                sel_op = eeprom_pkg::op_stop;
                next_state = eeprom_pkg::idle;
            end
            default:
                next_state = eeprom_pkg::idle;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_pkg::idle;
            is_rd <= 1'b0;
            pending <= 1'b0;
            err <= 1'b0;
            ack <= 1'b0;
            nack <= 1'b0;
            op_go <= 1'b0;
            op <= eeprom_pkg::op_start;
            op_last <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            op_go <= 1'b0;
            if (accept)
            begin
                state <= eeprom_pkg::start;
                is_rd <= !wr;   // write wins a tie
                err <= 1'b0;
            end
            else if (issue)
            begin
                op_go <= 1'b1;
                op <= sel_op;
                op_last <= sel_last;
                pending <= 1'b1;
            end
            else if (pending && op_done)
            begin
                pending <= 1'b0;
                if (state == eeprom_pkg::stop)
                begin
                    state <= eeprom_pkg::idle;
                    ack <= 1'b1;
                    nack <= err;
                end
                else if (rx_nack)
                begin
                    err <= 1'b1;
                    state <= eeprom_pkg::stop;   // abort, release the bus
                end
                else
                begin
                    state <= next_state;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_r <= addr;
            wdata_r <= wdata;
        end
        if (issue)
            op_byte <= sel_byte;
        if (pending && op_done && state == eeprom_pkg::data_rd)
            rdata <= rx_byte;
    end

endmodule

// File: source/i2c_bit_engine.sv
`include "eeprom_consts.svh"

module i2c_bit_engine
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    op_go,
    input  eeprom_pkg::bus_op_t     op,
    input  logic [`EE_DATA_W-1:0]   op_byte,
    input  logic                    op_last,
    output logic                    op_done,
    output logic [`EE_DATA_W-1:0]   rx_byte,
    output logic                    rx_nack,
    output logic                    scl,
    output logic                    sda_pull,
    input  logic                    sda_in
);

    localparam int HALF = `EE_HALF_SCL;
    localparam int MID = HALF / 2;
    localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;
    // start and stop span two half periods, a byte nine full SCL clocks
    localparam int LAST_SHORT = 1;
    localparam int LAST_BYTE = 2 * (`EE_DATA_W + 1) - 1;
    localparam int HALF_W = $clog2(LAST_BYTE + 1);

    logic                   active;
    eeprom_pkg::bus_op_t    cur_op;
    logic                   last_r;
    logic [CNT_W-1:0]       cnt;
    logic [HALF_W-1:0]      half;     // even = SCL low, odd = SCL high
    logic [`EE_DATA_W-1:0]  shreg;
    logic                   is_byte;
    logic                   ack_slot;
    logic                   mid_tick;
    logic                   end_tick;
    logic [HALF_W-1:0]      last_half;

    assign is_byte = (cur_op == eeprom_pkg::op_write) || (cur_op == eeprom_pkg::op_read);
    assign ack_slot = (half >> 1) == HALF_W'(`EE_DATA_W);
    assign mid_tick = active && (cnt == CNT_W'(MID));
    assign end_tick = active && (cnt == CNT_W'(HALF - 1));
    assign last_half = is_byte ? HALF_W'(LAST_BYTE) : HALF_W'(LAST_SHORT);

    assign rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            cur_op <= eeprom_pkg::op_start;
            last_r <= 1'b0;
            cnt <= '0;
            half <= '0;
            scl <= 1'b1;
            sda_pull <= 1'b0;
            op_done <= 1'b0;
            rx_nack <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                if (op_go)
                begin
                    active <= 1'b1;
                    cur_op <= op;
                    last_r <= op_last;
                    cnt <= '0;
                    half <= '0;
                    rx_nack <= 1'b0;
                end
            end
            else
            begin
                if (cnt == '0)
                    scl <= half[0];   // SCL edge at the start of each half
                if (mid_tick)
                begin
                    case (cur_op)
                        eeprom_pkg::op_start:
                            sda_pull <= half[0];     // falls while SCL high
                        eeprom_pkg::op_stop:
                            sda_pull <= ~half[0];    // rises while SCL high
                        eeprom_pkg::op_write:
                        begin
                            if (!half[0])
                                sda_pull <= ack_slot ? 1'b0 : ~shreg[`EE_DATA_W-1];
                            else if (ack_slot)
                                rx_nack <= sda_in;   // slave ack, low = ok
                        end
                        eeprom_pkg::op_read:
                        begin
                            if (!half[0])
                                sda_pull <= ack_slot ? ~last_r : 1'b0;
                        end
                        default:
                            sda_pull <= 1'b0;
                    endcase
                end
                if (end_tick)
                begin
                    cnt <= '0;
                    if (half == last_half)
                    begin
                        active <= 1'b0;
                        op_done <= 1'b1;
                    end
                    else
                    begin
                        half <= half + 1'b1;
                    end
                end
                else
                begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // shift register, sampled in the middle of SCL high
    // a write reads back its own bits, a read collects the slave data
    always_ff @(posedge CLK)
    begin
        if (!active && op_go)
            shreg <= op_byte;
        else if (mid_tick && is_byte && half[0] && !ack_slot)
            shreg <= {shreg[`EE_DATA_W-2:0], sda_in};
    end

endmodule

// File: source/eeprom_pkg.sv
package eeprom_pkg;

    // transaction sequencer states
    typedef enum logic [3:0]
    {
        idle,
        start,
        ctrl_wr,     // control byte, write direction
        word_addr,
        data_wr,
        restart,     // repeated start of a random read
        ctrl_rd,
        data_rd,
        stop
    } seq_state_t;

    // bus symbols understood by the bit engine
    typedef enum logic [1:0]
    {
        op_start,
        op_write,
        op_read,
        op_stop
    } bus_op_t;

endpackage

// File: include/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// CLK cycles per SCL half period
// keep at 2 or more so SDA moves mid-way through the low phase
`define EE_HALF_SCL 4

// 24Cxx device-type code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// 2 KB array, top three bits go out as block select
`define EE_ADDR_W 11

// one byte per transfer
`define EE_DATA_W 8

`endif
